/* flist.f */
+incdir+include
source/dcache_pkg.sv
source/dcache_ctrl_pe.sv
source/dcache_dir.sv
source/dcache_data.sv
source/dcache_ctrl.sv
verif/dcache_tb.sv

/* source/dcache_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl #(
    parameter int unsigned NUM_SETS   = 16,
    parameter int unsigned NUM_WAYS   = 2,
    parameter int unsigned LINE_WORDS = 4,
    localparam int unsigned WI_W      = $clog2(LINE_WORDS),
    localparam int unsigned LINE_W    = LINE_WORDS * dcache_pkg::WORD_W
) (
    input  wire logic                clk_i,
    input  wire logic                rst_ni,

    input  wire logic                core_req_valid_i,
    output logic                     core_req_ready_o,
    input  wire dcache_pkg::req_op_e core_req_op_i,
    input  wire dcache_pkg::addr_t   core_req_addr_i,
    input  wire dcache_pkg::word_t   core_req_wdata_i,
    input  wire dcache_pkg::be_t     core_req_be_i,
    input  wire dcache_pkg::tid_t    core_req_tid_i,

    output logic                     core_rsp_valid_o,
    output dcache_pkg::word_t        core_rsp_rdata_o,
    output dcache_pkg::tid_t         core_rsp_tid_o,

    output logic                     miss_valid_o,
    input  wire logic                miss_ready_i,
    output dcache_pkg::addr_t        miss_addr_o,
    output logic [WI_W-1:0]          miss_word_o,
    output dcache_pkg::tid_t         miss_tid_o,

    output logic                     wt_valid_o,
    input  wire logic                wt_ready_i,
    output dcache_pkg::addr_t        wt_addr_o,
    output dcache_pkg::word_t        wt_data_o,
    output dcache_pkg::be_t          wt_be_o,

    input  wire logic                refill_valid_i,
    output logic                     refill_ready_o,
    input  wire dcache_pkg::addr_t   refill_addr_i,
    input  wire logic [LINE_W-1:0]   refill_line_i,
    input  wire logic [WI_W-1:0]     refill_word_i,
    input  wire dcache_pkg::tid_t    refill_tid_i,

    output logic                     ctrl_empty_o,
    output logic                     evt_read_miss_o,
    output logic                     evt_stall_o
);

    localparam int unsigned SET_W    = $clog2(NUM_SETS);
    localparam int unsigned WORD_LSB = $clog2(dcache_pkg::BE_W);
    localparam int unsigned SET_LSB  = WORD_LSB + WI_W;
    localparam int unsigned TAG_LSB  = SET_LSB + SET_W;
    localparam int unsigned TAG_W    = dcache_pkg::ADDR_W - TAG_LSB;

    // Stage 1 request, payload only
    dcache_pkg::req_op_e  st1_op_q;
    dcache_pkg::addr_t    st1_addr_q;
    dcache_pkg::word_t    st1_wdata_q;
    dcache_pkg::be_t      st1_be_q;
    dcache_pkg::tid_t     st1_tid_q;

    // Stage 2 holds the load that missed
    dcache_pkg::addr_t    st2_addr_q;
    dcache_pkg::tid_t     st2_tid_q;

    logic [SET_W-1:0]     st0_set;
    logic [WI_W-1:0]      st0_word;
    logic                 st0_is_load;
    logic                 st0_read;

    logic                 st1_we;
    logic                 st1_valid;
    logic                 st1_is_store;
    logic                 st1_hit;
    logic                 st1_rsp_valid;
    logic                 st1_data_write;
    logic [SET_W-1:0]     st1_set;
    logic [WI_W-1:0]      st1_word;
    logic [TAG_W-1:0]     st1_tag;
    logic [NUM_WAYS-1:0]  st1_hit_way;
    dcache_pkg::word_t    st1_rdata;

    logic                 st2_we;
    logic                 st2_valid;

    logic                 refill_accept;
    logic [SET_W-1:0]     refill_set;
    logic [TAG_W-1:0]     refill_tag;
    logic [NUM_WAYS-1:0]  refill_way;
    dcache_pkg::word_t    refill_rdata;

    // Stage 0 decode, the core is the only request source
    assign st0_set     = core_req_addr_i[SET_LSB +: SET_W];
    assign st0_word    = core_req_addr_i[WORD_LSB +: WI_W];
    assign st0_is_load = (core_req_op_i == dcache_pkg::OP_LOAD);

    assign st1_set      = st1_addr_q[SET_LSB +: SET_W];
    assign st1_word     = st1_addr_q[WORD_LSB +: WI_W];
    assign st1_tag      = st1_addr_q[TAG_LSB +: TAG_W];
    assign st1_is_store = (st1_op_q == dcache_pkg::OP_STORE);
    assign st1_hit      = |st1_hit_way;

    assign refill_set    = refill_addr_i[SET_LSB +: SET_W];
    assign refill_tag    = refill_addr_i[TAG_LSB +: TAG_W];
    assign refill_accept = refill_valid_i & refill_ready_o;
    assign refill_rdata  = refill_line_i[refill_word_i*dcache_pkg::WORD_W +: dcache_pkg::WORD_W];

    dcache_ctrl_pe i_dcache_ctrl_pe (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .core_req_valid_i (core_req_valid_i),
        .st0_is_load_i    (st0_is_load),
        .refill_valid_i   (refill_valid_i),
        .st1_valid_i      (st1_valid),
        .st1_is_store_i   (st1_is_store),
        .st1_hit_i        (st1_hit),
        .st2_valid_i      (st2_valid),
        .miss_ready_i     (miss_ready_i),
        .wt_ready_i       (wt_ready_i),
        .core_req_ready_o (core_req_ready_o),
        .refill_ready_o   (refill_ready_o),
        .st0_read_o       (st0_read),
        .st1_we_o         (st1_we),
        .st1_valid_o      (st1_valid),
        .st1_rsp_valid_o  (st1_rsp_valid),
        .st1_data_write_o (st1_data_write),
        .st2_we_o         (st2_we),
        .st2_valid_o      (st2_valid),
        .wt_valid_o       (wt_valid_o),
        .evt_read_miss_o  (evt_read_miss_o),
        .evt_stall_o      (evt_stall_o)
    );

    always_ff @(posedge clk_i) begin
        if (st1_we) begin
            st1_op_q    <= core_req_op_i;
            st1_addr_q  <= core_req_addr_i;
            st1_wdata_q <= core_req_wdata_i;
            st1_be_q    <= core_req_be_i;
            st1_tid_q   <= core_req_tid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (st2_we) begin
            st2_addr_q <= st1_addr_q;
            st2_tid_q  <= st1_tid_q;
        end
    end

    // The tag is read for every request, data words only for loads
    dcache_dir #(
        .NUM_SETS   (NUM_SETS),
        .NUM_WAYS   (NUM_WAYS),
        .LINE_WORDS (LINE_WORDS)
    ) i_dcache_dir (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .read_i       (st1_we),
        .read_set_i   (st0_set),
        .st1_tag_i    (st1_tag),
        .hit_way_o    (st1_hit_way),
        .refill_i     (refill_accept),
        .refill_set_i (refill_set),
        .refill_tag_i (refill_tag),
        .refill_way_o (refill_way)
    );

    dcache_data #(
        .NUM_SETS   (NUM_SETS),
        .NUM_WAYS   (NUM_WAYS),
        .LINE_WORDS (LINE_WORDS)
    ) i_dcache_data (
        .clk_i         (clk_i),
        .read_i        (st0_read),
        .read_set_i    (st0_set),
        .read_word_i   (st0_word),
        .rdata_o       (st1_rdata),
        .hit_way_i     (st1_hit_way),
        .write_i       (st1_data_write),
        .write_set_i   (st1_set),
        .write_word_i  (st1_word),
        .wdata_i       (st1_wdata_q),
        .be_i          (st1_be_q),
        .refill_i      (refill_accept),
        .refill_way_i  (refill_way),
        .refill_set_i  (refill_set),
        .refill_line_i (refill_line_i)
    );

    assign miss_valid_o = st2_valid;
    assign miss_addr_o  = {st2_addr_q[dcache_pkg::ADDR_W-1:SET_LSB], {SET_LSB{1'b0}}};
    assign miss_word_o  = st2_addr_q[WORD_LSB +: WI_W];
    assign miss_tid_o   = st2_tid_q;

    assign wt_addr_o = st1_addr_q;
    assign wt_data_o = st1_wdata_q;
    assign wt_be_o   = st1_be_q;

    // Refill response wins over a stage 1 hit
    assign core_rsp_valid_o = refill_accept | st1_rsp_valid;
    assign core_rsp_rdata_o = refill_accept ? refill_rdata : st1_rdata;
    assign core_rsp_tid_o   = refill_accept ? refill_tid_i : st1_tid_q;

    assign ctrl_empty_o = ~(st1_valid | st2_valid);

endmodule

`default_nettype wire

/* source/dcache_ctrl_pe.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl_pe (
    input  wire logic clk_i,
    input  wire logic rst_ni,

    input  wire logic core_req_valid_i,
    input  wire logic st0_is_load_i,
    input  wire logic refill_valid_i,
    input  wire logic st1_valid_i,
    input  wire logic st1_is_store_i,
    input  wire logic st1_hit_i,
    input  wire logic st2_valid_i,
    input  wire logic miss_ready_i,
    input  wire logic wt_ready_i,

    output logic      core_req_ready_o,
    output logic      refill_ready_o,
    output logic      st0_read_o,
    output logic      st1_we_o,
    output logic      st1_valid_o,
    output logic      st1_rsp_valid_o,
    output logic      st1_data_write_o,
    output logic      st2_we_o,
    output logic      st2_valid_o,
    output logic      wt_valid_o,
    output logic      evt_read_miss_o,
    output logic      evt_stall_o
);

    logic st1_valid_q;
    logic st2_valid_q;

    logic refill_accept;
    logic st1_store;
    logic st2_free;
    logic st1_retire;
    logic st1_hold;
    logic core_accept;

    assign st1_store = st1_valid_i & st1_is_store_i;

    // A refill may not replace a way while a store hit is pending on it
    assign refill_ready_o = ~st1_store;
    assign refill_accept  = refill_valid_i & refill_ready_o;

    // Stage 2 takes a new miss when empty or handing its miss off now
    assign st2_free = ~st2_valid_i | miss_ready_i;

    always_comb begin
        st1_retire = 1'b0;
        if (st1_valid_i && !refill_accept) begin
            if (st1_is_store_i) begin
                st1_retire = wt_ready_i;
            end else if (st1_hit_i) begin
                st1_retire = 1'b1;
            end else begin
                st1_retire = st2_free;
            end
        end
    end

    assign st1_hold = st1_valid_i & ~st1_retire;

    // A store in stage 1 blocks stage 0 so no read sees the old word
    assign core_req_ready_o = ~refill_accept & ~st1_hold & ~st1_store;
    assign core_accept      = core_req_valid_i & core_req_ready_o;

    assign st1_we_o   = core_accept;
    assign st0_read_o = core_accept & st0_is_load_i;

    assign st1_rsp_valid_o  = st1_retire & ~st1_is_store_i & st1_hit_i;
    assign st1_data_write_o = st1_retire & st1_is_store_i & st1_hit_i;
    assign st2_we_o         = st1_retire & ~st1_is_store_i & ~st1_hit_i;
    assign wt_valid_o       = st1_store;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            st1_valid_q <= 1'b0;
            st2_valid_q <= 1'b0;
        end else begin
            st1_valid_q <= core_accept | st1_hold;
            st2_valid_q <= st2_we_o | (st2_valid_i & ~miss_ready_i);
        end
    end

    assign st1_valid_o = st1_valid_q;
    assign st2_valid_o = st2_valid_q;

    assign evt_read_miss_o = st2_we_o;
    assign evt_stall_o     = core_req_valid_i & ~core_req_ready_o;

endmodule

`default_nettype wire

/* source/dcache_data.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_data #(
    parameter int unsigned NUM_SETS   = 16,
    parameter int unsigned NUM_WAYS   = 2,
    parameter int unsigned LINE_WORDS = 4,
    localparam int unsigned SET_W     = $clog2(NUM_SETS),
    localparam int unsigned WI_W      = $clog2(LINE_WORDS),
    localparam int unsigned LINE_W    = LINE_WORDS * dcache_pkg::WORD_W
) (
    input  wire logic                clk_i,

    input  wire logic                read_i,
    input  wire logic [SET_W-1:0]    read_set_i,
    input  wire logic [WI_W-1:0]     read_word_i,
    output dcache_pkg::word_t        rdata_o,
    input  wire logic [NUM_WAYS-1:0] hit_way_i,

    input  wire logic                write_i,
    input  wire logic [SET_W-1:0]    write_set_i,
    input  wire logic [WI_W-1:0]     write_word_i,
    input  wire dcache_pkg::word_t   wdata_i,
    input  wire dcache_pkg::be_t     be_i,

    input  wire logic                refill_i,
    input  wire logic [NUM_WAYS-1:0] refill_way_i,
    input  wire logic [SET_W-1:0]    refill_set_i,
    input  wire logic [LINE_W-1:0]   refill_line_i
);

    dcache_pkg::word_t mem_q [NUM_WAYS][NUM_SETS][LINE_WORDS];
    dcache_pkg::word_t rd_q  [NUM_WAYS];

    // Every way is read, the hit way is picked in stage 1
    always_ff @(posedge clk_i) begin
        if (read_i) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                rd_q[w] <= mem_q[w][read_set_i][read_word_i];
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit_way_i[w]) begin
                rdata_o = rdata_o | rd_q[w];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (refill_i && refill_way_i[w]) begin
                for (int i = 0; i < LINE_WORDS; i++) begin
                    mem_q[w][refill_set_i][i] <=
                        refill_line_i[i*dcache_pkg::WORD_W +: dcache_pkg::WORD_W];
                end
            end else if (write_i && hit_way_i[w]) begin
                for (int b = 0; b < dcache_pkg::BE_W; b++) begin
                    if (be_i[b]) begin
                        mem_q[w][write_set_i][write_word_i][8*b +: 8] <= wdata_i[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/dcache_dir.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_dir #(
    parameter int unsigned NUM_SETS   = 16,
    parameter int unsigned NUM_WAYS   = 2,
    parameter int unsigned LINE_WORDS = 4,
    localparam int unsigned SET_W     = $clog2(NUM_SETS),
    localparam int unsigned TAG_W     = dcache_pkg::ADDR_W - $clog2(dcache_pkg::BE_W)
                                        - $clog2(LINE_WORDS) - SET_W
) (
    input  wire logic                clk_i,
    input  wire logic                rst_ni,

    input  wire logic                read_i,
    input  wire logic [SET_W-1:0]    read_set_i,
    input  wire logic [TAG_W-1:0]    st1_tag_i,
    output logic [NUM_WAYS-1:0]      hit_way_o,

    input  wire logic                refill_i,
    input  wire logic [SET_W-1:0]    refill_set_i,
    input  wire logic [TAG_W-1:0]    refill_tag_i,
    output logic [NUM_WAYS-1:0]      refill_way_o
);

    localparam int unsigned PTR_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

    logic [TAG_W-1:0]    tag_q      [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_q    [NUM_SETS];
    logic [PTR_W-1:0]    rr_q       [NUM_SETS];

    // Tags and valid bits read in stage 0
    logic [TAG_W-1:0]    rd_tag_q   [NUM_WAYS];
    logic [NUM_WAYS-1:0] rd_valid_q;

    logic [NUM_WAYS-1:0] match_way;
    logic [NUM_WAYS-1:0] free_way;
    logic                free_found;

    always_ff @(posedge clk_i) begin
        if (read_i) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                rd_tag_q[w] <= tag_q[read_set_i][w];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_valid_q <= '0;
        end else if (read_i) begin
            rd_valid_q <= valid_q[read_set_i];
        end
    end

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_way_o[w] = rd_valid_q[w] & (rd_tag_q[w] == st1_tag_i);
        end
    end

    // Victim choice: same tag, then first invalid way, then round robin
    always_comb begin
        free_way   = '0;
        free_found = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            match_way[w] = valid_q[refill_set_i][w] & (tag_q[refill_set_i][w] == refill_tag_i);
            if (!free_found && !valid_q[refill_set_i][w]) begin
                free_way[w] = 1'b1;
                free_found  = 1'b1;
            end
        end
        if (|match_way) begin
            refill_way_o = match_way;
        end else if (free_found) begin
            refill_way_o = free_way;
        end else begin
            refill_way_o = '0;
            refill_way_o[rr_q[refill_set_i]] = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (refill_i) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (refill_way_o[w]) begin
                    tag_q[refill_set_i][w] <= refill_tag_i;
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
                rr_q[s]    <= '0;
            end
        end else if (refill_i) begin
            valid_q[refill_set_i] <= valid_q[refill_set_i] | refill_way_o;
            if (rr_q[refill_set_i] == PTR_W'(NUM_WAYS - 1)) begin
                rr_q[refill_set_i] <= '0;
            end else begin
                rr_q[refill_set_i] <= rr_q[refill_set_i] + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    // Core-side widths
    parameter int unsigned ADDR_W = 32;
    parameter int unsigned WORD_W = 32;
    parameter int unsigned BE_W   = WORD_W / 8;
    parameter int unsigned TID_W  = 4;

    // Byte address
    typedef logic [ADDR_W-1:0] addr_t;

    // One data word
    typedef logic [WORD_W-1:0] word_t;

    // Byte enables of one word
    typedef logic [BE_W-1:0] be_t;

    // Transaction id of the requester
    typedef logic [TID_W-1:0] tid_t;

    // Request operation
    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } req_op_e;

endpackage

`default_nettype wire

/* include/dcache_tb_tasks.svh */
`ifndef DCACHE_TB_TASKS_SVH
`define DCACHE_TB_TASKS_SVH

function automatic int rand_pct();
    return int'($unsigned($random(seed)) % 100);
endfunction

function automatic int mem_index(input dcache_pkg::addr_t addr);
    return int'((addr >> 2) % MEM_WORDS);
endfunction

function automatic dcache_pkg::addr_t make_addr(input int tag, input int set, input int word);
    return dcache_pkg::addr_t'(((tag * NUM_SETS + set) * LINE_WORDS + word) * dcache_pkg::BE_W);
endfunction

function automatic logic loads_pending();
    logic busy;
    busy = 1'b0;
    for (int t = 0; t < NUM_TIDS; t++) begin
        busy = busy | pend[t];
    end
    return busy;
endfunction

// Oldest accepted miss gets the next refill
function automatic void drive_refill();
    dcache_pkg::addr_t line_addr;
    line_addr     = miss_addr_q.pop_front();
    refill_addr_i = line_addr;
    refill_word_i = miss_word_q.pop_front();
    refill_tid_i  = miss_tid_q.pop_front();
    for (int i = 0; i < LINE_WORDS; i++) begin
        refill_line_i[i*dcache_pkg::WORD_W +: dcache_pkg::WORD_W] =
            mem_model[mem_index(line_addr) + i];
    end
    refill_valid_i = 1'b1;
endfunction

// Event pulses against the handshakes seen so far
function automatic void check_events();
    assert (miss_evts == miss_reqs)
    else begin
        val_errs++;
        $display("Error %s: read-miss events expected %0d, actual %0d", test_name,
                 miss_reqs, miss_evts);
    end
    assert (stall_evts == stall_cycles)
    else begin
        val_errs++;
        $display("Error %s: stall events expected %0d, actual %0d", test_name,
                 stall_cycles, stall_evts);
    end
endfunction

// Every edge the request waits through is a refused cycle
task automatic wait_accept();
    do begin
        @(posedge clk_i);
        if (!core_req_ready_o) begin
            stall_cycles++;
        end
    end while (!core_req_ready_o);
    @(negedge clk_i);
    core_req_valid_i = 1'b0;
endtask

task automatic wait_loads();
    while (loads_pending()) begin
        @(negedge clk_i);
    end
endtask

task automatic check_idle();
    @(posedge clk_i);
    assert (ctrl_empty_o && core_req_ready_o && !core_rsp_valid_o && !miss_valid_o
            && !wt_valid_o)
    else begin
        proto_errs++;
        $display("Controller not idle after %s", test_name);
    end
    @(negedge clk_i);
    check_events();
endtask

task automatic drain();
    wait_loads();
    while (wt_expected) begin
        @(negedge clk_i);
    end
    check_idle();
endtask

task automatic issue_load(input dcache_pkg::addr_t addr, input int miss_kind);
    dcache_pkg::tid_t tid;
    tid = next_tid;
    while (pend[tid]) begin
        @(negedge clk_i);
    end
    next_tid         = next_tid + 1'b1;
    pend[tid]        = 1'b1;
    missed[tid]      = 1'b0;
    pend_addr[tid]   = addr;
    exp_miss[tid]    = miss_kind;
    exp_data[tid]    = mem_model[mem_index(addr)];
    core_req_valid_i = 1'b1;
    core_req_op_i    = dcache_pkg::OP_LOAD;
    core_req_addr_i  = addr;
    core_req_wdata_i = dcache_pkg::word_t'($random(seed));
    core_req_be_i    = '0;
    core_req_tid_i   = tid;
    wait_accept();
endtask

// Memory model only changes on the write-through, so wait for it
task automatic issue_store(input dcache_pkg::addr_t addr, input dcache_pkg::word_t data,
                           input dcache_pkg::be_t be);
    wait_loads();
    wt_exp_addr      = addr;
    wt_exp_data      = data;
    wt_exp_be        = be;
    wt_expected      = 1'b1;
    core_req_valid_i = 1'b1;
    core_req_op_i    = dcache_pkg::OP_STORE;
    core_req_addr_i  = addr;
    core_req_wdata_i = data;
    core_req_be_i    = be;
    core_req_tid_i   = '0;
    wait_accept();
    while (wt_expected) begin
        @(negedge clk_i);
    end
endtask

task automatic run_load_miss();
    test_name = "load_miss";
    for (int s = 0; s < 8; s++) begin
        issue_load(make_addr(1, s, s % LINE_WORDS), MUST_MISS);
    end
    drain();
endtask

task automatic run_load_hit();
    test_name = "load_hit";
    for (int s = 0; s < 8; s++) begin
        for (int w = 0; w < LINE_WORDS; w++) begin
            issue_load(make_addr(1, s, w), MUST_HIT);
        end
    end
    drain();
endtask

// Stores to cached lines, then to lines that were never loaded
task automatic run_store_wt();
    dcache_pkg::addr_t addr;
    test_name = "store_wt";
    for (int s = 0; s < 12; s++) begin
        if (s < 8) begin
            addr = make_addr(1, s, rand_pct() % LINE_WORDS);
        end else begin
            addr = make_addr(12, s - 8, rand_pct() % LINE_WORDS);
        end
        issue_store(addr, dcache_pkg::word_t'($random(seed)), dcache_pkg::be_t'($random(seed)));
        issue_load(addr, (s < 8) ? MUST_HIT : MUST_MISS);
    end
    drain();
endtask

task automatic run_backpressure();
    dcache_pkg::addr_t addr;
    int                r;
    test_name = "backpressure";
    ready_pct = 30;
    for (int n = 0; n < N_RAND; n++) begin
        r    = rand_pct();
        addr = make_addr(rand_pct() % 8, rand_pct() % 8, rand_pct() % LINE_WORDS);
        if (r < 20) begin
            issue_store(addr, dcache_pkg::word_t'($random(seed)),
                        dcache_pkg::be_t'($random(seed)));
        end else begin
            issue_load(addr, ANY_WAY);
        end
    end
    drain();
    ready_pct = 70;
endtask

// One line more than the set holds, the first one gets evicted
task automatic run_eviction();
    test_name = "eviction";
    for (int t = 1; t <= NUM_WAYS + 1; t++) begin
        issue_load(make_addr(t, EVICT_SET, 0), MUST_MISS);
    end
    drain();
    issue_load(make_addr(1, EVICT_SET, 1), MUST_MISS);
    drain();
    issue_load(make_addr(NUM_WAYS + 1, EVICT_SET, 2), MUST_HIT);
    drain();
endtask

`endif

/* verif/dcache_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_tb;

    localparam int unsigned NUM_SETS   = 16;
    localparam int unsigned NUM_WAYS   = 2;
    localparam int unsigned LINE_WORDS = 4;
    localparam int unsigned WI_W       = $clog2(LINE_WORDS);
    localparam int unsigned LINE_W     = LINE_WORDS * dcache_pkg::WORD_W;
    localparam int unsigned LINE_BYTES = LINE_WORDS * dcache_pkg::BE_W;
    localparam int unsigned MEM_WORDS  = 16 * NUM_SETS * LINE_WORDS;
    localparam int unsigned NUM_TIDS   = 2 ** dcache_pkg::TID_W;
    localparam int          CLK_PERIOD = 10;
    localparam int          N_RAND     = 200;
    localparam int          EVICT_SET  = NUM_SETS - 4;
    // Loads and stores issued over all tests
    localparam int          NUM_OPS    = 8 + 8 * LINE_WORDS + 24 + N_RAND + NUM_WAYS + 3;
    localparam int          OP_CYCLES  = 100;

    // Expected outcome of a load in the tag lookup
    localparam int MUST_HIT  = 0;
    localparam int MUST_MISS = 1;
    localparam int ANY_WAY   = 2;

    logic                      clk_i = 1'b0;
    logic                      rst_ni;
    logic                      core_req_valid_i;
    logic                      core_req_ready_o;
    dcache_pkg::req_op_e       core_req_op_i;
    dcache_pkg::addr_t         core_req_addr_i;
    dcache_pkg::word_t         core_req_wdata_i;
    dcache_pkg::be_t           core_req_be_i;
    dcache_pkg::tid_t          core_req_tid_i;
    logic                      core_rsp_valid_o;
    dcache_pkg::word_t         core_rsp_rdata_o;
    dcache_pkg::tid_t          core_rsp_tid_o;
    logic                      miss_valid_o;
    logic                      miss_ready_i;
    dcache_pkg::addr_t         miss_addr_o;
    logic [WI_W-1:0]           miss_word_o;
    dcache_pkg::tid_t          miss_tid_o;
    logic                      wt_valid_o;
    logic                      wt_ready_i;
    dcache_pkg::addr_t         wt_addr_o;
    dcache_pkg::word_t         wt_data_o;
    dcache_pkg::be_t           wt_be_o;
    logic                      refill_valid_i;
    logic                      refill_ready_o;
    dcache_pkg::addr_t         refill_addr_i;
    logic [LINE_W-1:0]         refill_line_i;
    logic [WI_W-1:0]           refill_word_i;
    dcache_pkg::tid_t          refill_tid_i;
    logic                      ctrl_empty_o;
    logic                      evt_read_miss_o;
    logic                      evt_stall_o;

    // Memory model and per-tid scoreboard
    dcache_pkg::word_t         mem_model [MEM_WORDS];
    dcache_pkg::word_t         exp_data  [NUM_TIDS];
    dcache_pkg::addr_t         pend_addr [NUM_TIDS];
    int                        exp_miss  [NUM_TIDS];
    logic                      pend      [NUM_TIDS];
    logic                      missed    [NUM_TIDS];
    dcache_pkg::tid_t          next_tid = '0;

    // Miss handler queue
    dcache_pkg::addr_t         miss_addr_q [$];
    logic [WI_W-1:0]           miss_word_q [$];
    dcache_pkg::tid_t          miss_tid_q  [$];
    logic                      refill_taken = 1'b0;

    logic                      wt_expected = 1'b0;
    dcache_pkg::addr_t         wt_exp_addr;
    dcache_pkg::word_t         wt_exp_data;
    dcache_pkg::be_t           wt_exp_be;

    // Event pulses and the handshakes they stand for
    int                        miss_evts    = 0;
    int                        miss_reqs    = 0;
    int                        stall_evts   = 0;
    int                        stall_cycles = 0;

    int                        val_errs   = 0;
    int                        proto_errs = 0;
    int                        ready_pct  = 70;
    int                        mon_idx;
    integer                    seed       = 32'h03f24b45;
    string                     test_name  = "reset";

    dcache_ctrl #(
        .NUM_SETS   (NUM_SETS),
        .NUM_WAYS   (NUM_WAYS),
        .LINE_WORDS (LINE_WORDS)
    ) i_dcache_ctrl (.*);

    `include "dcache_tb_tasks.svh"

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // Handshake bookkeeping, seen with pre-edge values
    always @(posedge clk_i) begin
        if (rst_ni) begin
            if (miss_valid_o && miss_ready_i) begin
                miss_addr_q.push_back(miss_addr_o);
                miss_word_q.push_back(miss_word_o);
                miss_tid_q.push_back(miss_tid_o);
                missed[miss_tid_o] = 1'b1;
                miss_reqs++;
            end
            if (evt_read_miss_o) begin
                miss_evts++;
            end
            if (evt_stall_o) begin
                stall_evts++;
            end
            if (refill_valid_i && refill_ready_o) begin
                refill_taken = 1'b1;
            end
            if (core_rsp_valid_o) begin
                pend[core_rsp_tid_o] = 1'b0;
            end
            if (wt_valid_o && wt_ready_i) begin
                mon_idx = mem_index(wt_addr_o);
                for (int b = 0; b < dcache_pkg::BE_W; b++) begin
                    if (wt_be_o[b]) begin
                        mem_model[mon_idx][8*b +: 8] = wt_data_o[8*b +: 8];
                    end
                end
                wt_expected = 1'b0;
            end
        end
    end

    // Ready strobes and the refill side of the miss handler
    always @(negedge clk_i) begin
        miss_ready_i = rand_pct() < ready_pct;
        wt_ready_i   = rand_pct() < ready_pct;
        if (refill_taken) begin
            refill_valid_i = 1'b0;
            refill_taken   = 1'b0;
        end
        if (!refill_valid_i && miss_addr_q.size() > 0 && rand_pct() < ready_pct) begin
            drive_refill();
        end
    end

    a_rsp_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
        core_rsp_valid_o |-> pend[core_rsp_tid_o])
        else begin
            proto_errs++;
            $display("Response in %s for tid %0d with no load in flight", test_name,
                     $sampled(core_rsp_tid_o));
        end

    a_rsp_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
        core_rsp_valid_o |-> core_rsp_rdata_o == exp_data[core_rsp_tid_o])
        else begin
            val_errs++;
            $display("Error %s: load data tid %0d expected %h, actual %h", test_name,
                     $sampled(core_rsp_tid_o), exp_data[$sampled(core_rsp_tid_o)],
                     $sampled(core_rsp_rdata_o));
        end

    a_rsp_missed: assert property (@(posedge clk_i) disable iff (!rst_ni)
        core_rsp_valid_o && exp_miss[core_rsp_tid_o] == MUST_MISS |-> missed[core_rsp_tid_o])
        else begin
            proto_errs++;
            $display("Load in %s was answered without the expected miss request", test_name);
        end

    // A load raises at most one miss request
    a_miss_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
        miss_valid_o |-> pend[miss_tid_o] && exp_miss[miss_tid_o] != MUST_HIT
            && !missed[miss_tid_o])
        else begin
            proto_errs++;
            $display("Miss request in %s for a load that must hit or already missed",
                     test_name);
        end

    a_miss_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
        miss_valid_o |-> miss_word_o == pend_addr[miss_tid_o][2 +: WI_W]
            && miss_addr_o == (pend_addr[miss_tid_o] & ~dcache_pkg::addr_t'(LINE_BYTES - 1)))
        else begin
            val_errs++;
            $display("Error %s: miss tid %0d expected %h word %0d, actual %h word %0d",
                     test_name, $sampled(miss_tid_o),
                     pend_addr[$sampled(miss_tid_o)] & ~dcache_pkg::addr_t'(LINE_BYTES - 1),
                     pend_addr[$sampled(miss_tid_o)][2 +: WI_W],
                     $sampled(miss_addr_o), $sampled(miss_word_o));
        end

    a_miss_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        miss_valid_o && !miss_ready_i |=> miss_valid_o && $stable(miss_addr_o)
            && $stable(miss_word_o) && $stable(miss_tid_o))
        else begin
            proto_errs++;
            $display("Miss request in %s dropped or changed while waiting", test_name);
        end

    a_wt_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wt_valid_o |-> wt_expected)
        else begin
            proto_errs++;
            $display("Write-through in %s with no store outstanding", test_name);
        end

    a_wt_payload: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wt_valid_o && wt_expected |-> wt_addr_o == wt_exp_addr && wt_data_o == wt_exp_data
            && wt_be_o == wt_exp_be)
        else begin
            val_errs++;
            $display("Error %s: write-through expected %h %h %h, actual %h %h %h", test_name,
                     wt_exp_addr, wt_exp_data, wt_exp_be, $sampled(wt_addr_o),
                     $sampled(wt_data_o), $sampled(wt_be_o));
        end

    a_wt_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wt_valid_o && !wt_ready_i |=> wt_valid_o && $stable(wt_addr_o)
            && $stable(wt_data_o) && $stable(wt_be_o))
        else begin
            proto_errs++;
            $display("Write-through in %s dropped or changed while waiting", test_name);
        end

    initial begin
        rst_ni           = 1'b0;
        core_req_valid_i = 1'b0;
        core_req_op_i    = dcache_pkg::OP_LOAD;
        core_req_addr_i  = '0;
        core_req_wdata_i = '0;
        core_req_be_i    = '0;
        core_req_tid_i   = '0;
        miss_ready_i     = 1'b0;
        wt_ready_i       = 1'b0;
        refill_valid_i   = 1'b0;
        refill_addr_i    = '0;
        refill_line_i    = '0;
        refill_word_i    = '0;
        refill_tid_i     = '0;
        for (int t = 0; t < NUM_TIDS; t++) begin
            pend[t]   = 1'b0;
            missed[t] = 1'b0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_model[i] = (32'(i) * 32'h0100_0193) ^ 32'h5eed_0000;
        end
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        check_idle();
        run_load_miss();
        run_load_hit();
        run_store_wt();
        run_backpressure();
        run_eviction();
        $display("Checks finished with %0d value errors and %0d protocol errors",
                 val_errs, proto_errs);
        if (val_errs == 0 && proto_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #((NUM_OPS * OP_CYCLES + 20) * CLK_PERIOD);
        $display("Timeout in %s, the tests did not finish in time", test_name);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
